// File: source/ethSwitchPkg.sv
/* Types and constants for the Eth1 receive slice of the four-port switch.
   Widths are fixed by Ethernet and IPv4; the CRC register runs MSB first, not inverted */
package ethSwitchPkg;

  typedef logic [7:0]  byteT;       // One received byte
  typedef logic [47:0] macAddrT;    // Ethernet address, first byte on wire in [47:40]
  typedef logic [3:0]  boardIdT;    // FPGA board number
  typedef logic [15:0] boardMaskT;  // One bit per board
  typedef logic [3:0]  portMaskT;   // One bit per switch port
  typedef logic [31:0] crcT;
  typedef logic [2:0]  regAddrT;
  typedef logic [31:0] regDataT;

  typedef enum logic [1:0] {
    RxIdle,    // Preamble, waiting for SFD
    RxHeader,  // Dest, source, EtherType
    RxData     // Everything after the header, FCS included
  } rxStateT;

  // Switch port numbering
  localparam logic [1:0] IndexEth1 = 2'd0;
  localparam logic [1:0] IndexEth2 = 2'd1;
  localparam logic [1:0] IndexPs   = 2'd2;
  localparam logic [1:0] IndexRt   = 2'd3;

  localparam macAddrT     BroadcastMac       = 48'hffff_ffff_ffff;
  localparam logic [23:0] LcsrCid            = 24'hfa610e;  // OUI of every FPGA board
  localparam logic [23:0] MulticastBit       = 24'h010000;  // Group bit of the first byte
  localparam logic [23:0] UdpMulticastOui    = 24'h01005e;
  localparam logic [15:0] FpgaRtMac          = 16'h1394;
  localparam logic [15:0] FpgaPsMac          = 16'h0300;
  localparam logic [31:0] FpgaUdpMulticastIp = 32'he000_0064;  // 224.0.0.100

  localparam byteT     SfdByte         = 8'hd5;
  localparam int       HeaderBytes     = 14;
  localparam crcT      CrcPoly         = 32'h04c1_1db7;
  localparam crcT      CrcInit         = 32'hffff_ffff;
  localparam crcT      CrcResidue      = 32'hc704_dd7b;  // Left over after a good FCS
  localparam logic [15:0] EtherTypeIpv4 = 16'h0800;
  localparam logic [4:0]  Ipv4HeaderFirst = 5'd0;   // Even offset, word aligned
  localparam logic [4:0]  Ipv4HeaderLast  = 5'd19;  // 20-byte header, no options

  // Register window
  localparam regDataT SwitchIdWord  = 32'h3057_5345;  // "ESW0" byte swapped
  localparam regAddrT RegSwitchId   = 3'd0;
  localparam regAddrT RegPortActive = 3'd1;
  localparam regAddrT RegHostHigh   = 3'd2;
  localparam regAddrT RegHostLow    = 3'd3;
  localparam regAddrT RegFpgaTable  = 3'd4;
  localparam regAddrT RegFrameCount = 3'd5;
  localparam regAddrT RegErrorCount = 3'd6;

endpackage

// File: source/crc32Byte.sv
`timescale 1ns/10ps
/* One byte of CRC-32 per call, no clock. Bit 0 of the byte goes in first
   as on the wire; seeding and the residue check belong to the caller */
module crc32Byte
  import ethSwitchPkg::*;
(
  input  byteT DataIn,
  input  crcT  CrcIn,
  output crcT  CrcOut
);

  always_comb begin : crcSteps
    crcT  crc;
    byteT dataRev;
    logic feedback;
    crc = CrcIn;
    // Reversed byte, MSB of dataRev is the first bit on the wire
    for (int i = 0; i < 8; i++) begin
      dataRev[i] = DataIn[7 - i];
    end
    for (int i = 7; i >= 0; i--) begin
      feedback = crc[31] ^ dataRev[i];
      crc = {crc[30:0], 1'b0} ^ (feedback ? CrcPoly : '0);  // One LFSR shift
    end
    CrcOut = crc;
  end

endmodule

// File: source/rxFrameParser.sv
`timescale 1ns/10ps
/* No preamble length check, any byte before SFD is skipped. IPv4 header is
   assumed to be 20 bytes without options. Frames that end in the header are dropped */
module rxFrameParser
  import ethSwitchPkg::*;
(
  input  logic    RxClk,
  input  logic    rst,
  input  logic    RxValid,
  input  logic    DataReady,
  input  byteT    RxD,
  output logic    HeaderDone,
  output macAddrT DestMac,
  output macAddrT SrcMac,
  output logic    FrameDone,
  output logic    CrcError,
  output logic    Ipv4Error
);

  rxStateT      rxState;
  logic [4:0]   byteCnt;      // Header index, then data offset saturating at 31
  logic [103:0] headerShift;  // First 13 header bytes, oldest on top
  logic [111:0] headerFull;   // Whole header once the 14th byte is on RxD
  logic         isIpv4;
  crcT          crcState;
  crcT          crcNext;
  logic [16:0]  cksum;        // Ones' complement sum, bit 16 is a pending carry
  logic [16:0]  cksumLast;
  logic         cksumOk;
  logic         ipv4Bad;
  logic         take;

  assign take       = RxValid & DataReady;  // DataReady low only stalls
  assign headerFull = {headerShift, RxD};
  assign cksumLast  = cksum + {9'd0, RxD};  // Odd byte, low half of a word
  // All ones once the carry is folded back
  assign cksumOk    = (cksumLast == 17'h0ffff) || (cksumLast == 17'h1fffe);

  crc32Byte crc32Byte_i (
    .DataIn (RxD),
    .CrcIn  (crcState),
    .CrcOut (crcNext)
  );

  always_ff @(posedge RxClk) begin
    if (take && rxState == RxIdle && RxD == SfdByte) begin
      crcState <= CrcInit;  // SFD itself is not covered
    end else if (take && rxState != RxIdle) begin
      crcState <= crcNext;
    end
    if (take && rxState == RxHeader) begin
      headerShift <= {headerShift[95:0], RxD};
      if (byteCnt == 5'(HeaderBytes - 1)) begin
        DestMac <= headerFull[111:64];
        SrcMac  <= headerFull[63:16];
        isIpv4  <= (headerFull[15:0] == EtherTypeIpv4);
      end
    end
    if (take && rxState == RxData) begin
      if (byteCnt == Ipv4HeaderFirst) begin
        cksum <= {1'b0, RxD, 8'd0};
      end else if (!byteCnt[0]) begin
        cksum <= {1'b0, cksum[15:0]} + {RxD, 7'd0, cksum[16]};  // High byte plus old carry
      end else begin
        cksum <= cksumLast;
      end
    end
  end

  always_ff @(posedge RxClk) begin
    if (rst) begin
      rxState    <= RxIdle;
      byteCnt    <= '0;
      HeaderDone <= 1'b0;
      FrameDone  <= 1'b0;
      CrcError   <= 1'b0;
      Ipv4Error  <= 1'b0;
      ipv4Bad    <= 1'b0;
    end else begin
      HeaderDone <= 1'b0;  // Both strobes last one cycle
      FrameDone  <= 1'b0;
      case (rxState)
        RxIdle: begin
          if (take && RxD == SfdByte) begin
            rxState <= RxHeader;
            byteCnt <= '0;
            ipv4Bad <= 1'b0;
          end
        end
        RxHeader: begin
          if (take) begin
            byteCnt <= byteCnt + 5'd1;
            if (byteCnt == 5'(HeaderBytes - 1)) begin
              byteCnt    <= '0;
              HeaderDone <= 1'b1;
              rxState    <= RxData;
            end
          end else if (!RxValid) begin
            rxState <= RxIdle;  // Runt, no pulses
          end
        end
        RxData: begin
          if (take) begin
            if (byteCnt != 5'd31) begin
              byteCnt <= byteCnt + 5'd1;
            end
            if (byteCnt == Ipv4HeaderLast) begin
              ipv4Bad <= isIpv4 & ~cksumOk;  // Non-IPv4 frames never flag
            end
          end else if (!RxValid) begin
            FrameDone <= 1'b1;
            CrcError  <= (crcState != CrcResidue);
            Ipv4Error <= ipv4Bad;
            rxState   <= RxIdle;
          end
        end
        default: rxState <= RxIdle;
      endcase
    end
  end

  // End of one frame and header of the next need at least an SFD between them
  headerFrameApart: assert property (@(posedge RxClk) disable iff (rst)
    !(HeaderDone && FrameDone));

endmodule

// File: source/macLearner.sv
`timescale 1ns/10ps
/* Learns only from Eth1 sources. One host MAC is kept, the last non-LCSR source seen.
   Board bits are never aged, only a link drop on Eth1 clears them */
module macLearner
  import ethSwitchPkg::*;
(
  input  logic      RxClk,
  input  logic      rst,
  input  logic      Eth1Active,
  input  logic      HeaderDone,
  input  macAddrT   SrcMac,
  output macAddrT   HostMac,
  output boardMaskT FpgaTable
);

  boardIdT srcBoard;

  assign srcBoard = SrcMac[3:0];  // Board number sits in the low nibble

  always_ff @(posedge RxClk) begin
    if (rst || !Eth1Active) begin
      HostMac   <= BroadcastMac;  // Unknown host
      FpgaTable <= '0;
    end else if (HeaderDone) begin
      // RT or PS source alike marks the board as reachable through Eth1
      if (SrcMac[47:24] == LcsrCid) begin
        FpgaTable[srcBoard] <= 1'b1;
      end else begin
        HostMac <= SrcMac;
      end
    end
  end

endmodule

// File: source/forwardDecision.sv
`timescale 1ns/10ps
/* Decides outputs for a frame arriving on Eth1. Eth2 never learns here, so its
   primary MAC is broadcast and every board not seen on Eth1 is assumed behind Eth2 */
module forwardDecision
  import ethSwitchPkg::*;
(
  input  logic      RxClk,
  input  logic      rst,
  input  logic      HeaderDone,
  input  macAddrT   DestMac,
  input  boardIdT   BoardId,
  input  boardMaskT FpgaTable,
  input  portMaskT  PortActive,
  output logic      ForwardValid,
  output portMaskT  ForwardMask
);

  macAddrT   primaryPs;
  macAddrT   primaryRt;
  boardMaskT ownBoard;
  boardMaskT eth2Action;   // Boards to reach through Eth2
  logic      isBroadcast;
  logic      isMulticastUdp;
  logic      isMulticastFpga;
  logic      isLcsr;
  logic      isMulticastLcsr;
  logic      matchEth2;
  logic      matchPs;
  logic      matchRt;
  logic      isFpgaMatch;
  logic      isNoMatch;
  portMaskT  maskNext;

  // Unicast needs the board byte, any multicast ignores it
  function automatic logic primaryMatch(macAddrT dest, macAddrT primary);
    return (dest[47:41] == primary[47:41]) && (dest[39:8] == primary[39:8]) &&
           ((dest[7:0] == primary[7:0]) || dest[40]);
  endfunction

  assign primaryPs = {LcsrCid, FpgaPsMac, 4'd0, BoardId};
  assign primaryRt = {LcsrCid, FpgaRtMac, 4'd0, BoardId};
  assign ownBoard   = boardMaskT'(1) << BoardId;
  assign eth2Action = ~(FpgaTable | ownBoard);

  assign isBroadcast     = (DestMac == BroadcastMac);
  assign isMulticastUdp  = (DestMac[47:24] == UdpMulticastOui);
  // Raw FPGA multicast or UDP multicast to the FPGA group IP
  assign isMulticastFpga = ((DestMac[47:24] == (LcsrCid | MulticastBit)) &&
                            (DestMac[7:0] == 8'hff)) ||
                           (isMulticastUdp && (DestMac[23:0] == FpgaUdpMulticastIp[23:0]));
  assign isLcsr          = ((DestMac[47:24] & ~MulticastBit) == LcsrCid);
  assign isMulticastLcsr = isLcsr & DestMac[40];

  assign matchEth2   = primaryMatch(DestMac, BroadcastMac);
  assign matchPs     = primaryMatch(DestMac, primaryPs);
  assign matchRt     = primaryMatch(DestMac, primaryRt);
  assign isFpgaMatch = (isLcsr & eth2Action[DestMac[3:0]]) | isMulticastLcsr | isMulticastFpga;
  assign isNoMatch   = ~(matchEth2 | matchPs | matchRt) & ~isFpgaMatch;  // Flood

  assign maskNext[IndexEth1] = 1'b0;  // Never back out the ingress port
  assign maskNext[IndexEth2] = PortActive[IndexEth2] &
                               (isBroadcast | isMulticastUdp | matchEth2 | isFpgaMatch | isNoMatch);
  assign maskNext[IndexPs]   = PortActive[IndexPs] &
                               (isBroadcast | (isMulticastUdp & ~isMulticastFpga) | matchPs);
  assign maskNext[IndexRt]   = PortActive[IndexRt] & (isBroadcast | isMulticastFpga | matchRt);

  // Same edge as the learner update, so the table seen here is the old one
  always_ff @(posedge RxClk) begin
    if (rst) begin
      ForwardValid <= 1'b0;
    end else begin
      ForwardValid <= HeaderDone;
    end
    if (HeaderDone) begin
      ForwardMask <= maskNext;
    end
  end

endmodule

// File: source/switchStats.sv
`timescale 1ns/10ps
/* Counters wrap silently. ClearErrors clears only the two error counts.
   RegData follows RegAddr with no clock, unused addresses read zero */
module switchStats
  import ethSwitchPkg::*;
(
  input  logic      RxClk,
  input  logic      rst,
  input  logic      FrameDone,
  input  logic      CrcError,
  input  logic      Ipv4Error,
  input  logic      ClearErrors,
  input  portMaskT  PortActive,
  input  macAddrT   HostMac,
  input  boardMaskT FpgaTable,
  input  regAddrT   RegAddr,
  output regDataT   RegData
);

  logic [15:0] frameCount;  // Every frame that reached FrameDone
  logic [7:0]  crcCount;
  logic [7:0]  ipv4Count;

  always_ff @(posedge RxClk) begin
    if (rst) begin
      frameCount <= '0;
      crcCount   <= '0;
      ipv4Count  <= '0;
    end else begin
      if (FrameDone) begin
        frameCount <= frameCount + 16'd1;
      end
      if (ClearErrors) begin
        crcCount  <= '0;  // Wins over a count in the same cycle
        ipv4Count <= '0;
      end else if (FrameDone) begin
        crcCount  <= crcCount + {7'd0, CrcError};
        ipv4Count <= ipv4Count + {7'd0, Ipv4Error};
      end
    end
  end

  always_comb begin
    case (RegAddr)
      RegSwitchId:   RegData = SwitchIdWord;
      RegPortActive: RegData = {28'd0, PortActive};
      RegHostHigh:   RegData = HostMac[47:16];
      RegHostLow:    RegData = {16'd0, HostMac[15:0]};
      RegFpgaTable:  RegData = {16'd0, FpgaTable};
      RegFrameCount: RegData = {16'd0, frameCount};
      RegErrorCount: RegData = {16'd0, ipv4Count, crcCount};
      default:       RegData = '0;
    endcase
  end

endmodule

// File: source/ethIngressSwitch.sv
`timescale 1ns/10ps
/* Receive side of Eth1 only, all on RxClk. The forward decision is a one-cycle
   mask pulse two cycles after the last header byte; no data path is included */
module ethIngressSwitch
  import ethSwitchPkg::*;
(
  input  logic     RxClk,
  input  logic     rst,
  input  logic     RxValid,
  input  logic     DataReady,
  input  byteT     RxD,
  input  portMaskT PortActive,
  input  boardIdT  BoardId,
  input  logic     ClearErrors,
  input  regAddrT  RegAddr,
  output logic     ForwardValid,
  output portMaskT ForwardMask,
  output logic     FrameDone,
  output logic     CrcError,
  output logic     Ipv4Error,
  output regDataT  RegData
);

  logic      headerDone;
  macAddrT   destMac;
  macAddrT   srcMac;
  macAddrT   hostMac;    // Learned Eth1 host
  boardMaskT fpgaTable;  // Boards seen on Eth1

  rxFrameParser rxFrameParser_i (
    .RxClk      (RxClk),
    .rst        (rst),
    .RxValid    (RxValid),
    .DataReady  (DataReady),
    .RxD        (RxD),
    .HeaderDone (headerDone),
    .DestMac    (destMac),
    .SrcMac     (srcMac),
    .FrameDone  (FrameDone),
    .CrcError   (CrcError),
    .Ipv4Error  (Ipv4Error)
  );

  macLearner macLearner_i (
    .RxClk      (RxClk),
    .rst        (rst),
    .Eth1Active (PortActive[IndexEth1]),
    .HeaderDone (headerDone),
    .SrcMac     (srcMac),
    .HostMac    (hostMac),
    .FpgaTable  (fpgaTable)
  );

  forwardDecision forwardDecision_i (
    .RxClk        (RxClk),
    .rst          (rst),
    .HeaderDone   (headerDone),
    .DestMac      (destMac),
    .BoardId      (BoardId),
    .FpgaTable    (fpgaTable),
    .PortActive   (PortActive),
    .ForwardValid (ForwardValid),
    .ForwardMask  (ForwardMask)
  );

  switchStats switchStats_i (
    .RxClk       (RxClk),
    .rst         (rst),
    .FrameDone   (FrameDone),
    .CrcError    (CrcError),
    .Ipv4Error   (Ipv4Error),
    .ClearErrors (ClearErrors),
    .PortActive  (PortActive),
    .HostMac     (hostMac),
    .FpgaTable   (fpgaTable),
    .RegAddr     (RegAddr),
    .RegData     (RegData)
  );

endmodule

// File: tests/ethIngressSwitchTb.sv
`timescale 1ns/10ps
/* Frames come from tests/framePatterns.txt, so run from the project root.
   BoardId is fixed at 3, the expected masks in the file assume that board */
module ethIngressSwitchTb
  import ethSwitchPkg::*;
();

  localparam int MaxFrames  = 32;
  localparam int Fields     = 9;    // Columns per line of the pattern file
  localparam int WaitCycles = 400;

  logic     RxClk;
  logic     rst;
  logic     RxValid;
  logic     DataReady;
  byteT     RxD;
  portMaskT PortActive;
  boardIdT  BoardId;
  logic     ClearErrors;
  regAddrT  RegAddr;
  logic     ForwardValid;
  portMaskT ForwardMask;
  logic     FrameDone;
  logic     CrcError;
  logic     Ipv4Error;
  regDataT  RegData;

  logic [47:0] patMem [0:MaxFrames*Fields-1];
  byteT        frameQ[$];      // Preamble through FCS
  logic [31:0] lfsrState;
  int          valueErrors;
  int          timeoutErrors;
  int          fwdCount = 0;   // Written only by the monitor
  int          doneCount = 0;
  portMaskT    fwdMaskSeen = '0;
  logic        crcSeen = 1'b0;
  logic        ipv4Seen = 1'b0;
  macAddrT     hostModel;      // Expected learner and counter state
  boardMaskT   tableModel;
  logic [15:0] frameModel;
  logic [7:0]  crcModel;
  logic [7:0]  ipv4Model;

  ethIngressSwitch ethIngressSwitch_i (.*);

  initial begin
    RxClk = 1'b0;
    forever #5 RxClk = ~RxClk;
  end

  // Outputs are stable mid-cycle
  always @(negedge RxClk) begin
    if (!rst && ForwardValid) begin
      fwdCount    = fwdCount + 1;
      fwdMaskSeen = ForwardMask;
    end
    if (!rst && FrameDone) begin
      doneCount = doneCount + 1;
      crcSeen   = CrcError;
      ipv4Seen  = Ipv4Error;
    end
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois taps 32,22,2,1
  endfunction

  // Reflected CRC-32, returns the FCS value sent low byte first
  function automatic logic [31:0] ethCrc(input int first, input int last);
    logic [31:0] crc;
    crc = 32'hffff_ffff;
    for (int i = first; i <= last; i++) begin
      crc = crc ^ {24'd0, frameQ[i]};
      for (int b = 0; b < 8; b++) begin
        crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
      end
    end
    return ~crc;
  endfunction

  function automatic logic [15:0] ipChecksum(input int first);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < 20; i += 2) begin
      sum = sum + {16'd0, frameQ[first + i], frameQ[first + i + 1]};
    end
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};  // Fold carries twice
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    return ~sum[15:0];
  endfunction

  task automatic buildFrame(input macAddrT dest, input macAddrT src, input logic [15:0] etype,
                            input logic badCrc, input logic badIpv4);
    byteT        ipHdr[20];
    logic [31:0] destIp;
    logic [15:0] cksum;
    logic [31:0] fcs;
    int          ipFirst;
    frameQ.delete();
    repeat (7) frameQ.push_back(8'h55);
    frameQ.push_back(SfdByte);
    for (int i = 5; i >= 0; i--) frameQ.push_back(dest[8*i +: 8]);
    for (int i = 5; i >= 0; i--) frameQ.push_back(src[8*i +: 8]);
    frameQ.push_back(etype[15:8]);
    frameQ.push_back(etype[7:0]);
    // Group MAC maps to a 224.x.y.z address
    destIp = (dest[47:24] == UdpMulticastOui) ? {8'he0, 1'b0, dest[22:0]} : 32'h0a00_0001;
    ipHdr = '{8'h45, 8'h00, 8'h00, 8'h2e, 8'h12, 8'h34, 8'h40, 8'h00, 8'h40, 8'h11,
              8'h00, 8'h00, 8'hc0, 8'ha8, 8'h00, 8'h01,
              destIp[31:24], destIp[23:16], destIp[15:8], destIp[7:0]};
    ipFirst = frameQ.size();
    foreach (ipHdr[i]) frameQ.push_back(ipHdr[i]);
    cksum = ipChecksum(ipFirst);
    if (badIpv4) cksum = cksum ^ 16'h0101;
    frameQ[ipFirst + 10] = cksum[15:8];
    frameQ[ipFirst + 11] = cksum[7:0];
    for (int i = 0; i < 26; i++) frameQ.push_back(byteT'(i * 7 + 3));  // Pad to 64 bytes
    fcs = ethCrc(8, frameQ.size() - 1);  // SFD is not covered
    if (badCrc) fcs = ~fcs;
    for (int k = 0; k < 4; k++) frameQ.push_back(fcs[8*k +: 8]);
  endtask

  task automatic sendFrame();
    logic [1:0] gap;
    foreach (frameQ[i]) begin
      gap[0]    = lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
      gap[1]    = lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
      if (gap == 2'b11) begin
        @(posedge RxClk);
        #1;
        RxValid   = 1'b1;
        DataReady = 1'b0;               // Stall inside the frame
        RxD       = frameQ[i] ^ 8'hff;  // Junk, must not be taken
      end
      @(posedge RxClk);
      #1;
      RxValid   = 1'b1;
      DataReady = 1'b1;
      RxD       = frameQ[i];
    end
    @(posedge RxClk);
    #1;
    RxValid = 1'b0;  // End of frame
    RxD     = '0;
  endtask

  task automatic checkReg(input regAddrT addr, input regDataT expected);
    @(posedge RxClk);
    #1;
    RegAddr = addr;
    @(negedge RxClk);
    assert (RegData == expected) else begin
      valueErrors++;
      $display("FAILED %0t: register %0d reads %h, expected %h", $time, addr, RegData,
               expected);
    end
  endtask

  task automatic runFrame(input int base);
    macAddrT     dest;
    macAddrT     src;
    logic [15:0] etype;
    portMaskT    act;
    portMaskT    expMask;
    logic        expCrc;
    logic        expIpv4;
    int          fwdBefore;
    int          doneBefore;
    int          waited;
    dest    = patMem[base];
    src     = patMem[base + 1];
    etype   = patMem[base + 2][15:0];
    act     = patMem[base + 5][3:0];
    expMask = patMem[base + 6][3:0];
    expCrc  = patMem[base + 7][0];
    expIpv4 = patMem[base + 8][0];
    @(posedge RxClk);
    #1;
    PortActive = act;
    if (!act[IndexEth1]) begin
      hostModel  = BroadcastMac;  // Link down on Eth1 forgets everything
      tableModel = '0;
    end
    fwdBefore  = fwdCount;
    doneBefore = doneCount;
    buildFrame(dest, src, etype, patMem[base + 3][0], patMem[base + 4][0]);
    sendFrame();
    waited = 0;
    while (doneCount == doneBefore && waited < WaitCycles) begin
      @(posedge RxClk);
      waited++;
    end
    if (doneCount == doneBefore) begin
      timeoutErrors++;
      $display("Timeout: no FrameDone for frame %0d to %h", base / Fields, dest);
      return;
    end
    assert (fwdCount == fwdBefore + 1) else begin
      valueErrors++;
      $display("FAILED %0t: %0d forward pulses for frame to %h", $time,
               fwdCount - fwdBefore, dest);
    end
    assert (fwdMaskSeen == expMask) else begin
      valueErrors++;
      $display("FAILED %0t: mask %b for frame to %h, expected %b", $time, fwdMaskSeen, dest,
               expMask);
    end
    assert (crcSeen == expCrc && ipv4Seen == expIpv4) else begin
      valueErrors++;
      $display("FAILED %0t: crc/ipv4 error %b%b for frame to %h, expected %b%b", $time,
               crcSeen, ipv4Seen, dest, expCrc, expIpv4);
    end
    frameModel = frameModel + 16'd1;
    crcModel   = crcModel + {7'd0, expCrc};
    ipv4Model  = ipv4Model + {7'd0, expIpv4};
    if (act[IndexEth1]) begin
      if (src[47:24] == LcsrCid) tableModel[src[3:0]] = 1'b1;
      else hostModel = src;
    end
    checkReg(RegHostHigh, hostModel[47:16]);
    checkReg(RegHostLow, {16'd0, hostModel[15:0]});
    checkReg(RegFpgaTable, {16'd0, tableModel});
    checkReg(RegFrameCount, {16'd0, frameModel});
    checkReg(RegErrorCount, {16'd0, ipv4Model, crcModel});
  endtask

  initial begin
    int base;
    rst           = 1'b1;
    RxValid       = 1'b0;
    DataReady     = 1'b0;
    RxD           = '0;
    PortActive    = 4'hf;
    BoardId       = 4'h3;
    ClearErrors   = 1'b0;
    RegAddr       = '0;
    lfsrState     = 32'hbc52;
    valueErrors   = 0;
    timeoutErrors = 0;
    hostModel     = BroadcastMac;
    tableModel    = '0;
    frameModel    = '0;
    crcModel      = '0;
    ipv4Model     = '0;
    for (int i = 0; i < MaxFrames * Fields; i++) patMem[i] = '0;  // Zero dest ends the list
    $readmemh("tests/framePatterns.txt", patMem);
    repeat (10) @(posedge RxClk);
    #1;
    rst = 1'b0;
    checkReg(RegSwitchId, SwitchIdWord);
    checkReg(RegFrameCount, 32'd0);
    base = 0;
    while (base < MaxFrames * Fields && patMem[base] != '0 && timeoutErrors == 0) begin
      runFrame(base);
      base += Fields;
    end
    if (timeoutErrors == 0) begin
      checkReg(RegPortActive, {28'd0, PortActive});
      @(posedge RxClk);
      #1;
      ClearErrors = 1'b1;
      @(posedge RxClk);
      #1;
      ClearErrors = 1'b0;
      checkReg(RegErrorCount, 32'd0);
      checkReg(RegFrameCount, {16'd0, frameModel});  // Frame count survives the clear
    end
    $display("Value errors: %0d, timeouts: %0d", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tests/framePatterns.txt
// dest src etherType badCrc badIpv4 portActive | expMask expCrcError expIpv4Error
// Masks: bit1 Eth2, bit2 PS, bit3 RT; board number is 3
ffffffffffff 001122334455 0800 0 0 f e 0 0
ffffffffffff fa610e030005 0800 0 0 b a 0 0
fa610e030003 001122334455 0800 0 0 f 4 0 0
fa610e139403 001122334455 0800 0 0 f 8 0 0
0a0b0c0d0e0f 001122334455 0800 0 0 f 2 0 0
fb610e0000ff fa610e139405 0800 0 0 f a 0 0
01005e000064 001122334455 0800 0 0 f a 0 0
01005e010203 001122334455 0800 0 0 f 6 0 0
ffffffffffff 001122334455 0800 1 0 f e 1 0
ffffffffffff 001122334455 0800 0 1 f e 0 1
0a0b0c0d0e0f 001122334455 0800 1 1 f 2 1 1
fa610e030009 fa610e139409 88b5 0 1 f 2 0 0
ffffffffffff 00aabbccddee 0800 0 0 e e 0 0
ffffffffffff 001122334455 0800 0 0 f e 0 0
fa610e139403 02aabbccddee 0800 0 0 7 0 0 0

// File: build.f
source/ethSwitchPkg.sv
source/crc32Byte.sv
source/rxFrameParser.sv
source/macLearner.sv
source/forwardDecision.sv
source/switchStats.sv
source/ethIngressSwitch.sv
tests/ethIngressSwitchTb.sv

// File: Makefile
# Verilator flow for the Eth1 ingress switch testbench
VERILATOR ?= verilator
TOP       ?= ethIngressSwitchTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSTEXT  ?= All checks passed
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
